// File: Makefile
# Verilator flow for the dual-clock FIFO

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= cdc_fifo_tb
RTL_TOP   ?= cdc_fifo_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Test OK

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/cdc_fifo_tb.sv
// Testbench for the dual-clock FIFO with clocks, reset, random traffic, scoreboard and checks
`timescale 1ns/10ps

module cdc_fifo_tb;
  import fifo_cfg_pkg::*;

  localparam int Depth = default_depth;
  localparam int Width = default_width;
  localparam int NumSyncStages = default_sync_stages;
  localparam int CountWidth = count_width_of(Depth);

  logic                  push_clk;
  logic                  push_rst_n;
  logic                  push_credit_stall;
  logic                  push_credit;
  logic                  push_valid;
  logic [     Width-1:0] push_data;
  logic                  push_full;
  logic [CountWidth-1:0] push_slots;
  logic                  pop_clk;
  logic                  pop_rst_n;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [     Width-1:0] pop_data;
  logic                  pop_empty;
  logic [CountWidth-1:0] pop_items;

  // Traffic controls set by the test sequence with modes 0 for low, 1 for high and 2 for random
  bit push_en;
  int stall_mode;
  int ready_mode;
  bit in_init;
  // Sender credit state and run totals
  int credits;
  int credits_received;
  int pushes;
  int pops;
  int errors;
  int tests_run;
  int tests_failed;
  logic [Width-1:0] sb [$];
  // DUT status captured at falling edges where it has settled
  bit full_seen;
  logic [CountWidth-1:0] slots_seen;
  bit empty_seen;
  logic [CountWidth-1:0] items_seen;

  cdc_fifo_top #(
    .Depth        (Depth),
    .Width        (Width),
    .NumSyncStages(NumSyncStages)
  ) UUT (
    .push_clk         (push_clk),
    .push_rst_n       (push_rst_n),
    .push_credit_stall(push_credit_stall),
    .push_credit      (push_credit),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_full        (push_full),
    .push_slots       (push_slots),
    .pop_clk          (pop_clk),
    .pop_rst_n        (pop_rst_n),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items)
  );

  // ------------------------------------------------
  // Clocks
  // ------------------------------------------------

  initial begin
    push_clk = 1'b0;
    forever #5 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    forever #7 pop_clk = ~pop_clk;
  end

  // ------------------------------------------------
  // Push side sender
  // ------------------------------------------------

  initial begin : push_driver
    int stall_left;
    stall_left = 0;
    forever begin
      @(posedge push_clk);
      #1;
      if (stall_mode == 2) begin
        // Random stall phases of a few cycles each
        if (stall_left == 0) begin
          push_credit_stall = ($urandom % 2) != 0;
          stall_left = 1 + $urandom % 12;
        end else begin
          stall_left--;
        end
      end else begin
        push_credit_stall = (stall_mode == 1);
      end
      // A credit granted on an earlier cycle is spent here
      if (push_rst_n && push_en && credits > 0 && ($urandom % 4) != 0) begin
        push_valid = 1'b1;
        push_data = Width'($urandom);
        sb.push_back(push_data);
        credits--;
        pushes++;
      end else begin
        push_valid = 1'b0;
      end
      @(negedge push_clk);
      full_seen = push_full;
      slots_seen = push_slots;
      if (push_rst_n && push_credit) begin
        credits++;
        credits_received++;
      end
      credit_limit_a: assert (credits <= Depth) else begin
        $display("error %0t: sender holds %0d credits, more than %0d", $time, credits, Depth);
        errors++;
      end
    end
  end

  // ------------------------------------------------
  // Pop side receiver and scoreboard
  // ------------------------------------------------

  initial begin : pop_driver
    int ready_left;
    logic [Width-1:0] expected;
    ready_left = 0;
    forever begin
      @(posedge pop_clk);
      #1;
      if (ready_mode == 2) begin
        if (ready_left == 0) begin
          pop_ready = ($urandom % 3) != 0;
          ready_left = 1 + $urandom % 12;
        end else begin
          ready_left--;
        end
      end else begin
        pop_ready = (ready_mode == 1);
      end
      @(negedge pop_clk);
      empty_seen = pop_empty;
      items_seen = pop_items;
      // Valid and ready both high now means a transfer on the coming edge
      if (pop_rst_n && pop_valid && pop_ready) begin
        sb_nonempty_a: assert (sb.size() > 0) else begin
          $display("pop transfer at %0t without any entry pushed", $time);
          errors++;
        end
        if (sb.size() > 0) begin
          expected = sb.pop_front();
          pops++;
          pop_data_a: assert (pop_data == expected) else begin
            $display("error %0t: pop_data %h, expected %h", $time, pop_data, expected);
            errors++;
          end
        end
      end
    end
  end

  // ------------------------------------------------
  // Protocol assertions
  // ------------------------------------------------

  init_idle_a: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
    in_init |-> (pop_empty && !pop_valid))
    else begin
      $display("error %0t: pop side not idle before the first push", $time);
      errors++;
    end

  stall_no_credit_a: assert property (@(posedge push_clk) disable iff (!push_rst_n)
    push_credit_stall |-> !push_credit)
    else begin
      $display("error %0t: credit pulse while stalled", $time);
      errors++;
    end

  hold_a: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)))
    else begin
      $display("error %0t: stalled pop entry changed to %h", $time, pop_data);
      errors++;
    end

  full_no_credit_a: assert property (@(posedge push_clk) disable iff (!push_rst_n)
    push_full |-> !push_credit)
    else begin
      $display("error %0t: credit pulse while full", $time);
      errors++;
    end

  // ------------------------------------------------
  // Reporting helpers
  // ------------------------------------------------

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errors++;
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin : main_seq
    int t;
    int base;
    int err0;
    void'($urandom(41));
    push_rst_n = 1'b0;
    pop_rst_n = 1'b0;
    push_credit_stall = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    push_en = 1'b0;
    stall_mode = 0;
    ready_mode = 0;
    in_init = 1'b1;
    repeat (8) @(posedge push_clk);
    #1;
    push_rst_n = 1'b1;
    pop_rst_n = 1'b1;

    // Initial credits arrive with no push at all
    err0 = errors;
    t = 0;
    while (credits < Depth && t < 100) begin
      @(posedge push_clk);
      t++;
    end
    if (credits < Depth) report_timeout("the initial credits");
    repeat (20) @(posedge push_clk);
    init_credit_a: assert (credits_received == Depth && pushes == 0) else begin
      $display("error %0t: %0d initial credits, expected %0d", $time, credits_received, Depth);
      errors++;
    end
    in_init = 1'b0;
    close_test("initial_credit", err0);

    // Random traffic exercises ordering and stall hold
    err0 = errors;
    push_en = 1'b1;
    stall_mode = 2;
    ready_mode = 2;
    t = 0;
    while (pushes < 200 && t < 20000) begin
      @(posedge push_clk);
      t++;
    end
    if (pushes < 200) report_timeout("200 random pushes");
    close_test("random_order", err0);

    // Long back-pressure fills the FIFO and stops the credits
    err0 = errors;
    stall_mode = 0;
    ready_mode = 0;
    repeat (10) @(posedge push_clk);
    t = 0;
    while (!full_seen && t < 500) begin
      @(posedge push_clk);
      t++;
    end
    if (!full_seen) report_timeout("push_full under back-pressure");
    base = credits_received;
    repeat (40) @(posedge push_clk);
    full_credit_a: assert (credits_received == base && full_seen) else begin
      $display("error %0t: %0d credits arrived while full", $time, credits_received - base);
      errors++;
    end
    close_test("back_pressure", err0);

    // Credits freed during a stall are owed and released afterwards
    err0 = errors;
    stall_mode = 1;
    ready_mode = 1;
    t = 0;
    while (credits > 0 && t < 500) begin
      @(posedge push_clk);
      t++;
    end
    if (credits > 0) report_timeout("the sender to spend its credits");
    push_en = 1'b0;
    t = 0;
    while (!(sb.size() == 0 && empty_seen && slots_seen == CountWidth'(Depth)) && t < 1000) begin
      @(posedge push_clk);
      t++;
    end
    if (sb.size() != 0 || !empty_seen || slots_seen != CountWidth'(Depth)) begin
      report_timeout("a drain under stall");
    end
    stall_held_a: assert (credits == 0) else begin
      $display("error %0t: sender holds %0d credits during stall", $time, credits);
      errors++;
    end
    stall_mode = 0;
    t = 0;
    while (credits < Depth && t < 200) begin
      @(posedge push_clk);
      t++;
    end
    if (credits < Depth) report_timeout("the credits held back by the stall");
    repeat (20) @(posedge push_clk);
    stall_release_a: assert (credits == Depth) else begin
      $display("error %0t: %0d credits after stall release, expected %0d", $time, credits, Depth);
      errors++;
    end
    close_test("credit_stall", err0);

    // A last burst of random traffic is followed by a full drain
    err0 = errors;
    base = pushes;
    push_en = 1'b1;
    stall_mode = 2;
    ready_mode = 2;
    t = 0;
    while (pushes < base + 100 && t < 10000) begin
      @(posedge push_clk);
      t++;
    end
    if (pushes < base + 100) report_timeout("the final random pushes");
    push_en = 1'b0;
    stall_mode = 0;
    ready_mode = 1;
    t = 0;
    while (!(sb.size() == 0 && empty_seen && credits == Depth) && t < 2000) begin
      @(posedge push_clk);
      t++;
    end
    if (sb.size() != 0 || !empty_seen || credits != Depth) report_timeout("the final drain");
    // A surplus credit returned by the push side would arrive within this window
    repeat (20) @(posedge push_clk);
    conserve_a: assert (credits_received == Depth + pops) else begin
      $display("error %0t: %0d credits received, expected %0d", $time, credits_received,
               Depth + pops);
      errors++;
    end
    close_test("credit_conservation", err0);
    err0 = errors;
    drain_a: assert (credits == Depth && empty_seen && items_seen == '0) else begin
      $display("error %0t: after drain credits %0d, empty %0b, items %0d", $time, credits,
               empty_seen, items_seen);
      errors++;
    end
    close_test("drain", err0);

    $display("tests %0d, failed %0d, errors %0d, pushes %0d, pops %0d", tests_run,
             tests_failed, errors, pushes, pops);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: cdc_fifo/cdc_fifo_ctrl.sv
// Dual-clock FIFO controller with push and pop control joined by Gray count synchronizers
`timescale 1ns/10ps

module cdc_fifo_ctrl #(
  parameter int Depth = fifo_cfg_pkg::default_depth,
  parameter int Width = fifo_cfg_pkg::default_width,
  parameter int NumSyncStages = fifo_cfg_pkg::default_sync_stages,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width_of(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width_of(Depth)
) (
  // Push domain
  input  logic                  push_clk,
  input  logic                  push_rst_n,
  input  logic                  push_credit_stall,
  output logic                  push_credit,
  input  logic                  push_valid,
  input  logic [     Width-1:0] push_data,
  output logic                  push_full,
  output logic [CountWidth-1:0] push_slots,
  output logic                  ram_wr_valid,
  output logic [ AddrWidth-1:0] ram_wr_addr,
  output logic [     Width-1:0] ram_wr_data,
  // Pop domain
  input  logic                  pop_clk,
  input  logic                  pop_rst_n,
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [     Width-1:0] pop_data,
  output logic                  pop_empty,
  output logic [CountWidth-1:0] pop_items,
  output logic                  ram_rd_valid,
  output logic [ AddrWidth-1:0] ram_rd_addr,
  input  logic [     Width-1:0] ram_rd_data
);

  // Counts named by owner then by the domain they are seen in
  logic [CountWidth-1:0] push_count_gray_push;
  logic [CountWidth-1:0] push_count_gray_pop;
  logic [CountWidth-1:0] pop_count_gray_pop;
  logic [CountWidth-1:0] pop_count_gray_push;

  cdc_fifo_push_ctrl #(
    .Depth(Depth),
    .Width(Width)
  ) push_ctrl (
    .push_clk         (push_clk),
    .rst_n            (push_rst_n),
    .push_credit_stall(push_credit_stall),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .pop_count_gray   (pop_count_gray_push),
    .push_credit      (push_credit),
    .push_full        (push_full),
    .push_slots       (push_slots),
    .ram_wr_valid     (ram_wr_valid),
    .ram_wr_addr      (ram_wr_addr),
    .ram_wr_data      (ram_wr_data),
    .push_count_gray  (push_count_gray_push)
  );

  // Push count travels to the pop side to reveal new entries
  cdc_fifo_gray_sync #(
    .CountWidth(CountWidth),
    .NumStages (NumSyncStages)
  ) sync_push2pop (
    .src_clk       (push_clk),
    .src_rst_n     (push_rst_n),
    .src_count_gray(push_count_gray_push),
    .dst_clk       (pop_clk),
    .dst_rst_n     (pop_rst_n),
    .dst_count_gray(push_count_gray_pop)
  );

  // Pop count travels back to the push side to free slots
  cdc_fifo_gray_sync #(
    .CountWidth(CountWidth),
    .NumStages (NumSyncStages)
  ) sync_pop2push (
    .src_clk       (pop_clk),
    .src_rst_n     (pop_rst_n),
    .src_count_gray(pop_count_gray_pop),
    .dst_clk       (push_clk),
    .dst_rst_n     (push_rst_n),
    .dst_count_gray(pop_count_gray_push)
  );

  cdc_fifo_pop_ctrl #(
    .Depth(Depth),
    .Width(Width)
  ) pop_ctrl (
    .pop_clk        (pop_clk),
    .rst_n          (pop_rst_n),
    .pop_ready      (pop_ready),
    .push_count_gray(push_count_gray_pop),
    .ram_rd_data    (ram_rd_data),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .pop_empty      (pop_empty),
    .pop_items      (pop_items),
    .ram_rd_valid   (ram_rd_valid),
    .ram_rd_addr    (ram_rd_addr),
    .pop_count_gray (pop_count_gray_pop)
  );

endmodule

// File: cdc_fifo/cdc_fifo_gray_sync.sv
// Gray count source register and multi-flop destination synchronizer
`timescale 1ns/10ps

module cdc_fifo_gray_sync #(
  parameter int CountWidth = fifo_cfg_pkg::count_width_of(fifo_cfg_pkg::default_depth),
  parameter int NumStages = fifo_cfg_pkg::default_sync_stages
) (
  input  logic                  src_clk,
  input  logic                  src_rst_n,
  input  logic [CountWidth-1:0] src_count_gray,
  input  logic                  dst_clk,
  input  logic                  dst_rst_n,
  output logic [CountWidth-1:0] dst_count_gray
);

  // Source flop keeps combinational glitches off the crossing
  logic [CountWidth-1:0] src_q;
  logic [CountWidth-1:0] sync_q [NumStages];

  always_ff @(posedge src_clk) begin
    if (!src_rst_n) begin
      src_q <= '0;
    end else begin
      src_q <= src_count_gray;
    end
  end

  // First stage samples asynchronously, later stages settle metastability
  always_ff @(posedge dst_clk) begin
    if (!dst_rst_n) begin
      for (int i = 0; i < NumStages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= src_q;
      for (int i = 1; i < NumStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign dst_count_gray = sync_q[NumStages-1];

  // Only a single bit may change per source edge or the sample can be torn
  gray_one_bit_a: assert property (@(posedge src_clk) disable iff (!src_rst_n)
    $countones(src_count_gray ^ src_q) <= 1);

endmodule

// File: cdc_fifo/cdc_fifo_pop_ctrl.sv
// Pop domain RAM read scheduling, staging register and Gray pop count
`timescale 1ns/10ps

module cdc_fifo_pop_ctrl #(
  parameter int Depth = fifo_cfg_pkg::default_depth,
  parameter int Width = fifo_cfg_pkg::default_width,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width_of(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width_of(Depth)
) (
  input  logic                  pop_clk,
  input  logic                  rst_n,
  input  logic                  pop_ready,
  input  logic [CountWidth-1:0] push_count_gray,
  input  logic [     Width-1:0] ram_rd_data,
  output logic                  pop_valid,
  output logic [     Width-1:0] pop_data,
  output logic                  pop_empty,
  output logic [CountWidth-1:0] pop_items,
  output logic                  ram_rd_valid,
  output logic [ AddrWidth-1:0] ram_rd_addr,
  output logic [CountWidth-1:0] pop_count_gray
);
  import fifo_cfg_pkg::*;
  import fifo_state_pkg::*;

  stage_phase_e          stage;
  logic [CountWidth-1:0] push_count;
  // Reads issued to the RAM, runs ahead of pop_count by the staged entry
  logic [CountWidth-1:0] rd_count;
  // Entries handed out on the pop interface
  logic [CountWidth-1:0] pop_count;
  logic [     Width-1:0] stage_data;
  logic                  xfer;

  // ------------------------------------------------
  // Counts and status
  // ------------------------------------------------

  assign push_count = CountWidth'(gray_to_bin(32'(push_count_gray)));

  // Items include the staged entry and any read still in flight
  assign pop_items = push_count - pop_count;
  assign pop_empty = (pop_items == '0);

  // Slots are only returned once the entry has left on the pop interface
  assign pop_count_gray = pop_count ^ (pop_count >> 1);

  // ------------------------------------------------
  // Read scheduling and staging
  // ------------------------------------------------

  assign pop_valid = (stage == STG_FULL);
  assign pop_data  = stage_data;
  assign xfer      = pop_valid && pop_ready;

  // Read when something is unread and staging is free or being emptied this cycle
  assign ram_rd_valid = (push_count != rd_count) && ((stage == STG_EMPTY) || xfer);
  assign ram_rd_addr  = rd_count[AddrWidth-1:0];

  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      stage     <= STG_EMPTY;
      rd_count  <= '0;
      pop_count <= '0;
    end else begin
      if (ram_rd_valid) begin
        rd_count <= rd_count + 1'b1;
      end
      if (xfer) begin
        pop_count <= pop_count + 1'b1;
      end
      case (stage)
        STG_EMPTY: begin
          if (ram_rd_valid) begin
            stage <= STG_WAIT;
          end
        end
        // RAM output register holds the data now, capture it next edge
        STG_WAIT: begin
          stage <= STG_FULL;
        end
        STG_FULL: begin
          if (xfer) begin
            stage <= ram_rd_valid ? STG_WAIT : STG_EMPTY;
          end
        end
        default: begin
          stage <= STG_EMPTY;
        end
      endcase
    end
  end

  // Staging payload only loads at the end of a read
  always_ff @(posedge pop_clk) begin
    if (stage == STG_WAIT) begin
      stage_data <= ram_rd_data;
    end
  end

  // Staged data counts as an item, so an empty FIFO never shows valid
  empty_not_valid_a: assert property (@(posedge pop_clk) disable iff (!rst_n)
    pop_empty |-> !pop_valid);

  // A stalled pop keeps its entry and data until taken
  stall_stable_a: assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)));

endmodule

// File: cdc_fifo/cdc_fifo_push_ctrl.sv
// Push domain credit issue, RAM write addressing and Gray push count
`timescale 1ns/10ps

module cdc_fifo_push_ctrl #(
  parameter int Depth = fifo_cfg_pkg::default_depth,
  parameter int Width = fifo_cfg_pkg::default_width,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width_of(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width_of(Depth)
) (
  input  logic                  push_clk,
  input  logic                  rst_n,
  input  logic                  push_credit_stall,
  input  logic                  push_valid,
  input  logic [     Width-1:0] push_data,
  input  logic [CountWidth-1:0] pop_count_gray,
  output logic                  push_credit,
  output logic                  push_full,
  output logic [CountWidth-1:0] push_slots,
  output logic                  ram_wr_valid,
  output logic [ AddrWidth-1:0] ram_wr_addr,
  output logic [     Width-1:0] ram_wr_data,
  output logic [CountWidth-1:0] push_count_gray
);
  import fifo_cfg_pkg::*;
  import fifo_state_pkg::*;

  localparam logic [CountWidth-1:0] DepthCount = CountWidth'(Depth);

  credit_phase_e         phase;
  // Low on the first cycle out of reset so no credit pulses there
  logic                  armed;
  logic [CountWidth-1:0] init_issued;
  logic [CountWidth-1:0] owed;
  // Credits granted to the sender and not yet used, kept for checking
  logic [CountWidth-1:0] outstanding;
  logic [CountWidth-1:0] push_count;
  logic [CountWidth-1:0] pop_count;
  logic [CountWidth-1:0] pop_seen;
  logic [CountWidth-1:0] freed;
  logic                  credit_avail;

  // ------------------------------------------------
  // Counts and status
  // ------------------------------------------------

  // Synchronized pop count arrives in Gray and is decoded here
  assign pop_count = CountWidth'(gray_to_bin(32'(pop_count_gray)));
  // Slots freed since the last cycle, the synchronizer may step by several
  assign freed = pop_count - pop_seen;

  assign push_slots = DepthCount - (push_count - pop_count);
  assign push_full  = (push_slots == '0);

  // Binary count only moves by one, so its Gray form changes one bit per edge
  assign push_count_gray = push_count ^ (push_count >> 1);

  // Writes happen in the cycle a push is accepted
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = push_count[AddrWidth-1:0];
  assign ram_wr_data  = push_data;

  // ------------------------------------------------
  // Credit issue
  // ------------------------------------------------

  // During the initial phase a credit is always ready, afterwards only when owed
  assign credit_avail = (phase == CRED_INIT) || (owed != '0);
  // Stall holds credits back in the same cycle, nothing is lost since owed keeps them
  assign push_credit  = armed && credit_avail && !push_credit_stall;

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_count  <= '0;
      pop_seen    <= '0;
      outstanding <= '0;
    end else begin
      pop_seen    <= pop_count;
      outstanding <= outstanding + CountWidth'(push_credit) - CountWidth'(push_valid);
      if (push_valid) begin
        push_count <= push_count + 1'b1;
      end
    end
  end

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      phase       <= CRED_INIT;
      armed       <= 1'b0;
      init_issued <= '0;
      owed        <= '0;
    end else begin
      armed <= 1'b1;
      if (phase == CRED_INIT) begin
        // Slots can already be freed here, bank them for the run phase
        owed <= owed + freed;
        if (push_credit) begin
          init_issued <= init_issued + 1'b1;
          if (init_issued == DepthCount - 1'b1) begin
            phase <= CRED_RUN;
          end
        end
      end else begin
        owed <= owed + freed - CountWidth'(push_credit);
      end
    end
  end

  // A push must spend a credit granted on an earlier cycle
  push_has_credit_a: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_valid |-> (outstanding != '0));

  // Credits held by the sender plus entries not yet seen as popped fit in the depth
  credit_bound_a: assert property (@(posedge push_clk) disable iff (!rst_n)
    ({1'b0, outstanding} + {1'b0, push_count - pop_seen}) <= {1'b0, DepthCount});

endmodule

// File: common/fifo_cfg_pkg.sv
// FIFO size defaults, derived-width helpers and Gray decoding
package fifo_cfg_pkg;

  // ------------------------------------------------
  // Defaults used by the top level
  // ------------------------------------------------

  // Depth must be a power of two so the Gray counts wrap cleanly at twice the depth
  localparam int default_depth = 8;
  localparam int default_width = 16;
  // Flops in each destination synchronizer chain
  localparam int default_sync_stages = 3;

  // ------------------------------------------------
  // Derived widths
  // ------------------------------------------------

  // Address width for a given depth, never less than one bit
  function automatic int addr_width_of(int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // Count width holds 0..depth, one bit wider than the address
  function automatic int count_width_of(int depth);
    return $clog2(depth + 1);
  endfunction

  // Gray to binary, each binary bit is the XOR of all Gray bits at or above it
  function automatic logic [31:0] gray_to_bin(logic [31:0] gray);
    logic [31:0] bin;
    bin[31] = gray[31];
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: common/fifo_state_pkg.sv
// State enums for the push credit phase and the pop staging phase
package fifo_state_pkg;

  // Push side credit phase
  typedef enum logic [1:0] {
    // Handing out the first Depth credits after reset
    CRED_INIT = 2'd0,
    // Returning one credit per slot freed by the pop side
    CRED_RUN  = 2'd1
  } credit_phase_e;

  // Pop side staging register phase
  typedef enum logic [1:0] {
    // Nothing staged and no read outstanding
    STG_EMPTY = 2'd0,
    // A RAM read is in flight, data lands next edge
    STG_WAIT  = 2'd1,
    // Staging holds the entry shown on pop_data
    STG_FULL  = 2'd2
  } stage_phase_e;

endpackage

// File: list.f
common/fifo_cfg_pkg.sv
common/fifo_state_pkg.sv
rtl/fifo_ram_1r1w.sv
cdc_fifo/cdc_fifo_gray_sync.sv
cdc_fifo/cdc_fifo_push_ctrl.sv
cdc_fifo/cdc_fifo_pop_ctrl.sv
cdc_fifo/cdc_fifo_ctrl.sv
rtl/cdc_fifo_top.sv
bench/cdc_fifo_tb.sv

// File: rtl/cdc_fifo_top.sv
// Dual-clock FIFO top level with controller and flop RAM
`timescale 1ns/10ps

module cdc_fifo_top #(
  parameter int Depth = fifo_cfg_pkg::default_depth,
  parameter int Width = fifo_cfg_pkg::default_width,
  parameter int NumSyncStages = fifo_cfg_pkg::default_sync_stages,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width_of(Depth),
  localparam int CountWidth = fifo_cfg_pkg::count_width_of(Depth)
) (
  input  logic                  push_clk,
  input  logic                  push_rst_n,
  input  logic                  push_credit_stall,
  output logic                  push_credit,
  input  logic                  push_valid,
  input  logic [     Width-1:0] push_data,
  output logic                  push_full,
  output logic [CountWidth-1:0] push_slots,
  input  logic                  pop_clk,
  input  logic                  pop_rst_n,
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [     Width-1:0] pop_data,
  output logic                  pop_empty,
  output logic [CountWidth-1:0] pop_items
);

  // RAM write side is in push_clk, read side in pop_clk
  logic                 ram_wr_valid;
  logic [AddrWidth-1:0] ram_wr_addr;
  logic [    Width-1:0] ram_wr_data;
  logic                 ram_rd_valid;
  logic [AddrWidth-1:0] ram_rd_addr;
  logic [    Width-1:0] ram_rd_data;

  cdc_fifo_ctrl #(
    .Depth        (Depth),
    .Width        (Width),
    .NumSyncStages(NumSyncStages)
  ) ctrl (
    .push_clk         (push_clk),
    .push_rst_n       (push_rst_n),
    .push_credit_stall(push_credit_stall),
    .push_credit      (push_credit),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_full        (push_full),
    .push_slots       (push_slots),
    .ram_wr_valid     (ram_wr_valid),
    .ram_wr_addr      (ram_wr_addr),
    .ram_wr_data      (ram_wr_data),
    .pop_clk          (pop_clk),
    .pop_rst_n        (pop_rst_n),
    .pop_ready        (pop_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_empty        (pop_empty),
    .pop_items        (pop_items),
    .ram_rd_valid     (ram_rd_valid),
    .ram_rd_addr      (ram_rd_addr),
    .ram_rd_data      (ram_rd_data)
  );

  fifo_ram_1r1w #(
    .Depth(Depth),
    .Width(Width)
  ) ram (
    .wr_clk  (push_clk),
    .wr_valid(ram_wr_valid),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_clk  (pop_clk),
    .rd_valid(ram_rd_valid),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

endmodule

// File: rtl/fifo_ram_1r1w.sv
// Flop array with a push clock write port and a registered pop clock read port
`timescale 1ns/10ps

module fifo_ram_1r1w #(
  parameter int Depth = fifo_cfg_pkg::default_depth,
  parameter int Width = fifo_cfg_pkg::default_width,
  localparam int AddrWidth = fifo_cfg_pkg::addr_width_of(Depth)
) (
  input  logic                 wr_clk,
  input  logic                 wr_valid,
  input  logic [AddrWidth-1:0] wr_addr,
  input  logic [    Width-1:0] wr_data,
  input  logic                 rd_clk,
  input  logic                 rd_valid,
  input  logic [AddrWidth-1:0] rd_addr,
  output logic [    Width-1:0] rd_data
);

  logic [Width-1:0] mem [Depth];

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------

  always_ff @(posedge wr_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // One cycle of read latency, output holds between reads
  // The entry read was written several push cycles earlier, so the array is settled
  always_ff @(posedge rd_clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule
